//--- cfgbus_params.svh
/*
  Size and address map constants for the configuration bus.
  CFG_MBOX_DEPTH must be a power of two, since the FIFO pointers wrap by
  overflow. Every valid address carries CFG_BASE_HI in its upper half.
*/
`ifndef CFGBUS_PARAMS_SVH
`define CFGBUS_PARAMS_SVH

// Data and address word width
`define CFG_DATA_W 32

// Upper address half shared by all targets
`define CFG_BASE_HI 16'h1040

// Region numbers in address bits 15:12
`define CFG_REGION_H2C   4'd2
`define CFG_REGION_C2H   4'd3
`define CFG_REGION_DBELL 4'd4

`define CFG_MBOX_DEPTH  8
`define CFG_SHMEM_WORDS 8

`endif

//--- cfgbus_pkg.sv
/*
  Shared types of the configuration bus.
  The address is one 32-bit word that is read either raw or as
  base, region and offset fields. Port and target enums are 1 and 2 bits.
*/
`default_nettype none

`include "cfgbus_params.svh"

package cfgbus_pkg;

  typedef struct packed {
    logic [15:0] base;
    logic [3:0]  region;
    logic [11:0] offset;
  } cfg_addr_fields_t;

  typedef union packed {
    logic [`CFG_DATA_W-1:0] raw;
    cfg_addr_fields_t       fields;
  } cfg_addr_u;

  typedef enum logic {
    PORT_HOST    = 1'b0,
    PORT_CLUSTER = 1'b1
  } cfg_port_e;

  typedef enum logic [1:0] {
    TGT_H2C   = 2'd0,
    TGT_C2H   = 2'd1,
    TGT_DBELL = 2'd2,
    TGT_ERR   = 2'd3
  } cfg_target_e;

  typedef struct packed {
    logic                   write;
    cfg_addr_u              addr;
    logic [`CFG_DATA_W-1:0] wdata;
  } cfg_req_t;

  // Payload carried between pipeline stages
  typedef struct packed {
    cfg_req_t    req;
    cfg_port_e   port;
    cfg_target_e target;
    logic        valid;
  } cfg_stage_t;

  typedef struct packed {
    logic [`CFG_DATA_W-1:0] rdata;
    logic                   err;
  } cfg_resp_t;

endpackage

`default_nettype wire

//--- cfgbus_arbiter.sv
/*
  Round-robin arbitration stage between host and cluster.
  Ready is combinational from the valids and is high for one port at most.
  Requesters must keep valid low during reset and hold their request
  until ready. The host wins the first contended cycle after reset.
*/
`timescale 1ns/1ps
`default_nettype none

module cfgbus_arbiter
  import cfgbus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       host_valid_i,
  input  logic       cluster_valid_i,
  input  cfg_req_t   host_req_i,
  input  cfg_req_t   cluster_req_i,
  output logic       host_ready_o,
  output logic       cluster_ready_o,
  output cfg_stage_t stage_o
);

  cfg_port_e  prio_q;
  cfg_stage_t stage_q;
  logic       grant_host;
  logic       grant_cluster;
  logic       contended;

  always_comb begin
    contended     = host_valid_i & cluster_valid_i;
    grant_host    = host_valid_i & (~cluster_valid_i | (prio_q == PORT_HOST));
    grant_cluster = cluster_valid_i & ~grant_host;
  end

  assign host_ready_o    = grant_host;
  assign cluster_ready_o = grant_cluster;

  // Pointer only moves when both ports competed
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= PORT_HOST;
    end else if (contended) begin
      prio_q <= (prio_q == PORT_HOST) ? PORT_CLUSTER : PORT_HOST;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_q.valid <= 1'b0;
    end else begin
      stage_q.valid <= grant_host | grant_cluster;
    end
    if (grant_host | grant_cluster) begin
      stage_q.req  <= grant_host ? host_req_i : cluster_req_i;
      stage_q.port <= grant_host ? PORT_HOST : PORT_CLUSTER;
      // Filled in by the decoder
      stage_q.target <= TGT_ERR;
    end
  end

  assign stage_o = stage_q;

endmodule

`default_nettype wire

//--- cfgbus_decoder.sv
/*
  Address decode stage.
  An address maps only if its base is CFG_BASE_HI and its region is one of
  the three target regions. Anything else is tagged as a decode error.
*/
`timescale 1ns/1ps
`default_nettype none

`include "cfgbus_params.svh"

module cfgbus_decoder
  import cfgbus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  cfg_stage_t stage_i,
  output cfg_stage_t stage_o
);

  cfg_addr_fields_t fields;
  cfg_target_e      target_d;
  cfg_stage_t       stage_q;

  always_comb begin
    fields = stage_i.req.addr.fields;
    if (fields.base != `CFG_BASE_HI) begin
      target_d = TGT_ERR;
    end else begin
      case (fields.region)
        `CFG_REGION_H2C:   target_d = TGT_H2C;
        `CFG_REGION_C2H:   target_d = TGT_C2H;
        `CFG_REGION_DBELL: target_d = TGT_DBELL;
        default:           target_d = TGT_ERR;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_q.valid <= 1'b0;
    end else begin
      stage_q.valid <= stage_i.valid;
    end
    stage_q.req    <= stage_i.req;
    stage_q.port   <= stage_i.port;
    stage_q.target <= target_d;
  end

  assign stage_o = stage_q;

endmodule

`default_nettype wire

//--- cfgbus_mailbox.sv
/*
  Host-to-cluster and cluster-to-host mailbox FIFOs.
  Offset 0x000 pushes on write, 0x004 pops on read, 0x008 reads status
  with full in bit 8 and count in the low bits. A push to a full FIFO is
  dropped with error, a pop from an empty FIFO returns error and zero.
  The response is combinational; state changes on the next edge.
*/
`timescale 1ns/1ps
`default_nettype none

`include "cfgbus_params.svh"

module cfgbus_mailbox
  import cfgbus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      sel_h2c_i,
  input  logic      sel_c2h_i,
  input  cfg_req_t  req_i,
  output cfg_resp_t resp_o,
  output logic      h2c_irq_o,
  output logic      c2h_irq_o
);

  localparam int PTR_W = $clog2(`CFG_MBOX_DEPTH);
  localparam int CNT_W = $clog2(`CFG_MBOX_DEPTH + 1);
  localparam logic [11:0] OFS_PUSH   = 12'h000;
  localparam logic [11:0] OFS_POP    = 12'h004;
  localparam logic [11:0] OFS_STATUS = 12'h008;

  // Index 0 is h2c and index 1 is c2h
  logic [`CFG_DATA_W-1:0] mem_q [2][`CFG_MBOX_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q [2];
  logic [PTR_W-1:0]       rd_ptr_q [2];
  logic [CNT_W-1:0]       count_q [2];
  logic                   c2h_nonempty_q;

  logic idx;
  logic sel;
  logic full;
  logic empty;
  logic do_push;
  logic do_pop;

  always_comb begin
    sel     = sel_h2c_i | sel_c2h_i;
    idx     = sel_c2h_i;
    full    = (count_q[idx] == CNT_W'(`CFG_MBOX_DEPTH));
    empty   = (count_q[idx] == '0);
    do_push = 1'b0;
    do_pop  = 1'b0;
    resp_o  = '0;
    case (req_i.addr.fields.offset)
      OFS_PUSH: begin
        if (req_i.write && !full) begin
          do_push = sel;
        end else begin
          resp_o.err = 1'b1;
        end
      end
      OFS_POP: begin
        if (!req_i.write && !empty) begin
          do_pop       = sel;
          resp_o.rdata = mem_q[idx][rd_ptr_q[idx]];
        end else begin
          resp_o.err = 1'b1;
        end
      end
      OFS_STATUS: begin
        if (!req_i.write) begin
          resp_o.rdata[8]         = full;
          resp_o.rdata[CNT_W-1:0] = count_q[idx];
        end else begin
          resp_o.err = 1'b1;
        end
      end
      default: resp_o.err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[idx][wr_ptr_q[idx]] <= req_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 2; i++) begin
        wr_ptr_q[i] <= '0;
        rd_ptr_q[i] <= '0;
        count_q[i]  <= '0;
      end
      c2h_nonempty_q <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q[idx] <= wr_ptr_q[idx] + 1'b1;
        count_q[idx]  <= count_q[idx] + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q[idx] <= rd_ptr_q[idx] + 1'b1;
        count_q[idx]  <= count_q[idx] - 1'b1;
      end
      c2h_nonempty_q <= (count_q[1] != '0);
    end
  end

  assign h2c_irq_o = (count_q[0] != '0);

  // High for one cycle when the c2h FIFO leaves empty
  assign c2h_irq_o = (count_q[1] != '0) & ~c2h_nonempty_q;

endmodule

`default_nettype wire

//--- cfgbus_doorbell.sv
/*
  Doorbell and completion flags with shared message memory.
  Offset 0x000 is the doorbell flag, 0x004 the completion flag; a write
  loads data bit 0. Shared memory sits at 0x100 upwards, word aligned.
  Other offsets return error. Interrupts follow the flags directly.
*/
`timescale 1ns/1ps
`default_nettype none

`include "cfgbus_params.svh"

module cfgbus_doorbell
  import cfgbus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      sel_i,
  input  cfg_req_t  req_i,
  output cfg_resp_t resp_o,
  output logic      doorbell_irq_o,
  output logic      completion_irq_o
);

  localparam int SHM_IDX_W = $clog2(`CFG_SHMEM_WORDS);
  localparam logic [11:0] OFS_DBELL = 12'h000;
  localparam logic [11:0] OFS_COMPL = 12'h004;
  localparam logic [11:0] OFS_SHMEM = 12'h100;
  localparam logic [11:0] OFS_SHEND = OFS_SHMEM + 12'(4 * `CFG_SHMEM_WORDS);

  logic                   doorbell_q;
  logic                   completion_q;
  logic [`CFG_DATA_W-1:0] shmem_q [`CFG_SHMEM_WORDS];

  logic [11:0]          offset;
  logic                 in_shmem;
  logic [SHM_IDX_W-1:0] shm_idx;
  logic                 wr_en;

  always_comb begin
    offset   = req_i.addr.fields.offset;
    in_shmem = (offset >= OFS_SHMEM) && (offset < OFS_SHEND) && (offset[1:0] == 2'b00);
    shm_idx  = offset[SHM_IDX_W+1:2];
    wr_en    = sel_i & req_i.write;
    resp_o   = '0;
    if (offset == OFS_DBELL) begin
      resp_o.rdata[0] = doorbell_q;
    end else if (offset == OFS_COMPL) begin
      resp_o.rdata[0] = completion_q;
    end else if (in_shmem) begin
      resp_o.rdata = shmem_q[shm_idx];
    end else begin
      resp_o.err = 1'b1;
    end
    // Writes return zero data
    if (req_i.write) begin
      resp_o.rdata = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      doorbell_q   <= 1'b0;
      completion_q <= 1'b0;
    end else if (wr_en) begin
      if (offset == OFS_DBELL) begin
        doorbell_q <= req_i.wdata[0];
      end
      if (offset == OFS_COMPL) begin
        completion_q <= req_i.wdata[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && in_shmem) begin
      shmem_q[shm_idx] <= req_i.wdata;
    end
  end

  assign doorbell_irq_o   = doorbell_q;
  assign completion_irq_o = completion_q;

endmodule

`default_nettype wire

//--- cfgbus_target_stage.sv
/*
  Target access stage.
  Performs the access in the selected target and registers the response.
  Response data goes to both ports; only the origin port sees a valid.
  Decode errors return error with zero data and touch no target.
*/
`timescale 1ns/1ps
`default_nettype none

module cfgbus_target_stage
  import cfgbus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  cfg_stage_t stage_i,
  output logic       host_resp_valid_o,
  output logic       cluster_resp_valid_o,
  output cfg_resp_t  host_resp_o,
  output cfg_resp_t  cluster_resp_o,
  output logic       h2c_irq_o,
  output logic       c2h_irq_o,
  output logic       doorbell_irq_o,
  output logic       completion_irq_o
);

  logic      sel_h2c;
  logic      sel_c2h;
  logic      sel_dbell;
  cfg_resp_t mbox_resp;
  cfg_resp_t dbell_resp;
  cfg_resp_t resp_d;
  cfg_resp_t resp_q;
  logic      host_valid_q;
  logic      cluster_valid_q;

  always_comb begin
    sel_h2c   = stage_i.valid && (stage_i.target == TGT_H2C);
    sel_c2h   = stage_i.valid && (stage_i.target == TGT_C2H);
    sel_dbell = stage_i.valid && (stage_i.target == TGT_DBELL);
    case (stage_i.target)
      TGT_H2C, TGT_C2H: resp_d = mbox_resp;
      TGT_DBELL:        resp_d = dbell_resp;
      default: begin
        resp_d.rdata = '0;
        resp_d.err   = 1'b1;
      end
    endcase
  end

  cfgbus_mailbox u_mailbox (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .sel_h2c_i (sel_h2c),
    .sel_c2h_i (sel_c2h),
    .req_i     (stage_i.req),
    .resp_o    (mbox_resp),
    .h2c_irq_o (h2c_irq_o),
    .c2h_irq_o (c2h_irq_o)
  );

  cfgbus_doorbell u_doorbell (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .sel_i            (sel_dbell),
    .req_i            (stage_i.req),
    .resp_o           (dbell_resp),
    .doorbell_irq_o   (doorbell_irq_o),
    .completion_irq_o (completion_irq_o)
  );

  always_ff @(posedge clk_i) begin
    resp_q <= resp_d;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      host_valid_q    <= 1'b0;
      cluster_valid_q <= 1'b0;
    end else begin
      host_valid_q    <= stage_i.valid && (stage_i.port == PORT_HOST);
      cluster_valid_q <= stage_i.valid && (stage_i.port == PORT_CLUSTER);
    end
  end

  assign host_resp_valid_o    = host_valid_q;
  assign cluster_resp_valid_o = cluster_valid_q;
  assign host_resp_o          = resp_q;
  assign cluster_resp_o       = resp_q;

endmodule

`default_nettype wire

//--- cfgbus_top.sv
/*
  Configuration bus top level.
  Three registered stages: arbitrate, decode, target access. A request
  accepted on one edge returns its response three cycles later on its own
  port. Responses have no back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

module cfgbus_top
  import cfgbus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      host_valid_i,
  input  logic      cluster_valid_i,
  input  cfg_req_t  host_req_i,
  input  cfg_req_t  cluster_req_i,
  output logic      host_ready_o,
  output logic      cluster_ready_o,
  output logic      host_resp_valid_o,
  output logic      cluster_resp_valid_o,
  output cfg_resp_t host_resp_o,
  output cfg_resp_t cluster_resp_o,
  output logic      h2c_irq_o,
  output logic      c2h_irq_o,
  output logic      doorbell_irq_o,
  output logic      completion_irq_o
);

  cfg_stage_t arb_stage;
  cfg_stage_t dec_stage;

  cfgbus_arbiter u_arbiter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .host_valid_i    (host_valid_i),
    .cluster_valid_i (cluster_valid_i),
    .host_req_i      (host_req_i),
    .cluster_req_i   (cluster_req_i),
    .host_ready_o    (host_ready_o),
    .cluster_ready_o (cluster_ready_o),
    .stage_o         (arb_stage)
  );

  cfgbus_decoder u_decoder (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .stage_i (arb_stage),
    .stage_o (dec_stage)
  );

  cfgbus_target_stage u_target_stage (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .stage_i              (dec_stage),
    .host_resp_valid_o    (host_resp_valid_o),
    .cluster_resp_valid_o (cluster_resp_valid_o),
    .host_resp_o          (host_resp_o),
    .cluster_resp_o       (cluster_resp_o),
    .h2c_irq_o            (h2c_irq_o),
    .c2h_irq_o            (c2h_irq_o),
    .doorbell_irq_o       (doorbell_irq_o),
    .completion_irq_o     (completion_irq_o)
  );

endmodule

`default_nettype wire

//--- cfgbus_clkgen.sv
/*
  Testbench clock and reset source.
  4 ns clock period. Reset is high from time zero and drops on the
  fifth rising edge.
*/
`timescale 1ns/1ps
`default_nettype none

module cfgbus_clkgen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    reset_o <= 1'b1;
    repeat (5) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- cfgbus_properties.sv
/*
  Concurrent checks on the request handshake and the response latency.
  Bound into cfgbus_top. All checks are off while reset is high.
  The fixed latency of 3 cycles matches the three-stage pipeline.
*/
`timescale 1ns/1ps
`default_nettype none

module cfgbus_properties (
  input logic clk_i,
  input logic reset_i,
  input logic host_valid_i,
  input logic cluster_valid_i,
  input logic host_ready_o,
  input logic cluster_ready_o,
  input logic host_resp_valid_o,
  input logic cluster_resp_valid_o
);

  a_one_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    !(host_ready_o && cluster_ready_o))
    else $error("host and cluster ready are high together");

  a_host_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    host_resp_valid_o == $past(host_valid_i && host_ready_o, 3))
    else $error("host response valid does not follow its handshake by 3 cycles");

  a_cluster_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    cluster_resp_valid_o == $past(cluster_valid_i && cluster_ready_o, 3))
    else $error("cluster response valid does not follow its handshake by 3 cycles");

  a_one_resp: assert property (@(posedge clk_i) disable iff (reset_i)
    !(host_resp_valid_o && cluster_resp_valid_o))
    else $error("host and cluster response valid are high together");

endmodule

`default_nettype wire

//--- cfgbus_tb.sv
/*
  Testbench for the configuration bus.
  Reads cfgbus_cases.txt: a case count, then one host and one cluster
  transaction per line. A response is expected exactly 3 cycles after its
  handshake, and the interrupt vector {h2c, c2h, doorbell, completion}
  is checked in that same cycle. Outputs are sampled on rising edges.
*/
`timescale 1ns/1ps
`default_nettype none

module cfgbus_tb
  import cfgbus_pkg::*;
();

  localparam int MAX_CASES  = 64;
  localparam int CASE_WORDS = 14;
  localparam int LATENCY    = 3;

  typedef struct packed {
    logic [31:0] cycle;
    cfg_resp_t   resp;
    logic [3:0]  irq;
  } expect_t;

  logic       clk;
  logic       reset;
  logic       host_valid;
  logic       cluster_valid;
  cfg_req_t   host_req;
  cfg_req_t   cluster_req;
  logic       host_ready;
  logic       cluster_ready;
  logic       host_resp_valid;
  logic       cluster_resp_valid;
  cfg_resp_t  host_resp;
  cfg_resp_t  cluster_resp;
  logic       h2c_irq;
  logic       c2h_irq;
  logic       doorbell_irq;
  logic       completion_irq;
  logic [3:0] irq_vec;
  logic       c2h_irq_prev;

  logic [31:0] case_mem [1 + CASE_WORDS * MAX_CASES];
  expect_t     exp_q [2][$];
  expect_t     host_next;
  expect_t     cluster_next;
  int          num_cases;
  int          cycle;
  int          cycle_limit;
  int          value_errors;
  int          protocol_errors;

  assign irq_vec = {h2c_irq, c2h_irq, doorbell_irq, completion_irq};

  cfgbus_clkgen u_clkgen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  cfgbus_top u_cfgbus_top (
    .clk_i                (clk),
    .reset_i              (reset),
    .host_valid_i         (host_valid),
    .cluster_valid_i      (cluster_valid),
    .host_req_i           (host_req),
    .cluster_req_i        (cluster_req),
    .host_ready_o         (host_ready),
    .cluster_ready_o      (cluster_ready),
    .host_resp_valid_o    (host_resp_valid),
    .cluster_resp_valid_o (cluster_resp_valid),
    .host_resp_o          (host_resp),
    .cluster_resp_o       (cluster_resp),
    .h2c_irq_o            (h2c_irq),
    .c2h_irq_o            (c2h_irq),
    .doorbell_irq_o       (doorbell_irq),
    .completion_irq_o     (completion_irq)
  );

  bind cfgbus_top cfgbus_properties u_properties (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .host_valid_i         (host_valid_i),
    .cluster_valid_i      (cluster_valid_i),
    .host_ready_o         (host_ready_o),
    .cluster_ready_o      (cluster_ready_o),
    .host_resp_valid_o    (host_resp_valid_o),
    .cluster_resp_valid_o (cluster_resp_valid_o)
  );

  // Case words per port are active, write, address, wdata, rdata, err and irq
  function automatic cfg_req_t case_req(input int w);
    cfg_req_t req;
    req.write    = case_mem[w][0];
    req.addr.raw = case_mem[w + 1];
    req.wdata    = case_mem[w + 2];
    return req;
  endfunction

  function automatic expect_t case_expect(input int w);
    expect_t item;
    item.cycle      = '0;
    item.resp.rdata = case_mem[w];
    item.resp.err   = case_mem[w + 1][0];
    item.irq        = case_mem[w + 2][3:0];
    return item;
  endfunction

  task automatic check_resp(input cfg_resp_t got, input cfg_resp_t exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s response data %h err %b, expected data %h err %b",
               $time, what, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_irq(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s interrupts %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic track_port(input int p, input string name, input logic handshake,
                            input expect_t next, input logic resp_valid,
                            input cfg_resp_t resp);
    expect_t item;
    logic    due;
    due = 1'b0;
    if (exp_q[p].size() != 0) begin
      item = exp_q[p][0];
      due  = (item.cycle + LATENCY == cycle);
    end
    if (due) begin
      void'(exp_q[p].pop_front());
      if (!resp_valid) begin
        protocol_errors++;
        $display("Error: %s response missing in cycle %0d", name, cycle);
      end else begin
        check_resp(resp, item.resp, name);
        check_irq(irq_vec, item.irq, name);
      end
    end else if (resp_valid) begin
      protocol_errors++;
      $display("Error: unexpected %s response in cycle %0d", name, cycle);
    end
    if (handshake) begin
      item       = next;
      item.cycle = cycle;
      exp_q[p].push_back(item);
    end
  endtask

  task automatic run_case(input int base);
    logic host_act;
    logic cluster_act;
    host_act    = case_mem[base][0];
    cluster_act = case_mem[base + 7][0];
    @(posedge clk);
    if (host_act) begin
      host_next = case_expect(base + 4);
      host_req   <= case_req(base + 1);
      host_valid <= 1'b1;
    end
    if (cluster_act) begin
      cluster_next = case_expect(base + 11);
      cluster_req   <= case_req(base + 8);
      cluster_valid <= 1'b1;
    end
    // Hold each request until its own ready
    while (host_act || cluster_act) begin
      @(posedge clk);
      if (host_act && host_ready) begin
        host_valid <= 1'b0;
        host_act = 1'b0;
      end
      if (cluster_act && cluster_ready) begin
        cluster_valid <= 1'b0;
        cluster_act = 1'b0;
      end
    end
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (!reset) begin
      if (host_ready && cluster_ready) begin
        protocol_errors++;
        $display("Error: both ready outputs high in cycle %0d", cycle);
      end
      // The c2h interrupt is a pulse of one cycle
      if (c2h_irq && c2h_irq_prev) begin
        protocol_errors++;
        $display("Error: c2h interrupt stayed high for more than one cycle in cycle %0d",
                 cycle);
      end
      c2h_irq_prev = c2h_irq;
      track_port(0, "host", host_valid && host_ready, host_next,
                 host_resp_valid, host_resp);
      track_port(1, "cluster", cluster_valid && cluster_ready, cluster_next,
                 cluster_resp_valid, cluster_resp);
    end
  end

  initial begin : watchdog
    int count;
    count = 0;
    @(posedge clk);
    while (count < cycle_limit) begin
      count++;
      @(posedge clk);
    end
    $display("Error: run did not finish within %0d cycles", cycle_limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int idle;
    host_valid    <= 1'b0;
    cluster_valid <= 1'b0;
    host_req      <= '0;
    cluster_req   <= '0;
    host_next       = '0;
    cluster_next    = '0;
    c2h_irq_prev    = 1'b0;
    cycle           = 0;
    value_errors    = 0;
    protocol_errors = 0;
    void'($urandom(30));
    $readmemh("cfgbus_cases.txt", case_mem);
    num_cases   = case_mem[0];
    cycle_limit = num_cases * 8 + 100;
    if (num_cases < 1 || num_cases > MAX_CASES) begin
      $display("Error: cfgbus_cases.txt is missing or holds a bad case count");
      $display("Finished with errors");
      $finish;
    end else begin
      @(posedge clk);
      while (reset) @(posedge clk);
      for (int n = 0; n < num_cases; n++) begin
        idle = $urandom % 3;
        repeat (idle) @(posedge clk);
        run_case(1 + n * CASE_WORDS);
      end
      repeat (LATENCY + 2) @(posedge clk);
      for (int p = 0; p < 2; p++) begin
        if (exp_q[p].size() != 0) begin
          protocol_errors += exp_q[p].size();
          $display("Error: %0d responses never arrived on port %0d", exp_q[p].size(), p);
        end
      end
      $display("Summary: %0d value errors, %0d protocol errors",
               value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0) begin
        $display("Finished with no errors");
      end else begin
        $display("Finished with errors");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- cfgbus_cases.txt
// First word: case count. Then per line, host then cluster:
// active write addr wdata rdata err irq{h2c,c2h,dbell,compl}
24
1 0 10502000 00000000 00000000 1 0  0 0 00000000 00000000 00000000 0 0
0 0 00000000 00000000 00000000 0 0  1 1 10405000 12345678 00000000 1 0
1 1 10402000 A0000001 00000000 0 8  0 0 00000000 00000000 00000000 0 0
1 1 10402000 A0000002 00000000 0 8  0 0 00000000 00000000 00000000 0 0
1 0 10402008 00000000 00000002 0 8  0 0 00000000 00000000 00000000 0 0
0 0 00000000 00000000 00000000 0 0  1 0 10402004 00000000 A0000001 0 8
0 0 00000000 00000000 00000000 0 0  1 0 10402004 00000000 A0000002 0 0
0 0 00000000 00000000 00000000 0 0  1 0 10402004 00000000 00000000 1 0
1 1 10402000 B0000001 00000000 0 8  1 1 10402000 B0000002 00000000 0 8
1 1 10402000 B0000003 00000000 0 8  1 1 10402000 B0000004 00000000 0 8
1 1 10402000 B0000005 00000000 0 8  1 1 10402000 B0000006 00000000 0 8
1 1 10402000 B0000007 00000000 0 8  1 1 10402000 B0000008 00000000 0 8
1 1 10402000 B0000009 00000000 1 8  0 0 00000000 00000000 00000000 0 0
0 0 00000000 00000000 00000000 0 0  1 0 10402008 00000000 00000108 0 8
1 0 10402004 00000000 B0000001 0 8  1 0 10402004 00000000 B0000002 0 8
1 0 10402004 00000000 B0000003 0 8  1 0 10402004 00000000 B0000004 0 8
1 0 10402004 00000000 B0000005 0 8  1 0 10402004 00000000 B0000006 0 8
1 0 10402004 00000000 B0000007 0 0  1 0 10402004 00000000 B0000008 0 8
1 0 10402004 00000000 00000000 1 0  0 0 00000000 00000000 00000000 0 0
0 0 00000000 00000000 00000000 0 0  1 1 10403000 C0000001 00000000 0 4
0 0 00000000 00000000 00000000 0 0  1 1 10403000 C0000002 00000000 0 0
1 0 10403008 00000000 00000002 0 0  0 0 00000000 00000000 00000000 0 0
1 0 10403004 00000000 C0000001 0 0  0 0 00000000 00000000 00000000 0 0
1 0 10403004 00000000 C0000002 0 0  0 0 00000000 00000000 00000000 0 0
1 1 10404000 00000001 00000000 0 2  0 0 00000000 00000000 00000000 0 0
0 0 00000000 00000000 00000000 0 0  1 1 10404004 00000001 00000000 0 3
0 0 00000000 00000000 00000000 0 0  1 0 10404000 00000000 00000001 0 3
1 0 10404004 00000000 00000001 0 3  0 0 00000000 00000000 00000000 0 0
1 1 10404000 00000000 00000000 0 1  0 0 00000000 00000000 00000000 0 0
0 0 00000000 00000000 00000000 0 0  1 1 10404004 00000002 00000000 0 0
1 1 10404100 D0000000 00000000 0 0  1 1 1040411C D000001C 00000000 0 0
1 0 1040411C 00000000 D000001C 0 0  1 0 10404100 00000000 D0000000 0 0
1 0 10404008 00000000 00000000 1 0  0 0 00000000 00000000 00000000 0 0
1 1 10402000 E0000001 00000000 0 8  0 0 00000000 00000000 00000000 0 0
0 0 00000000 00000000 00000000 0 0  1 1 10412000 E0000002 00000000 1 8
1 0 10402008 00000000 00000001 0 8  0 0 00000000 00000000 00000000 0 0

//--- verilog.f
+incdir+.
cfgbus_pkg.sv
cfgbus_arbiter.sv
cfgbus_decoder.sv
cfgbus_mailbox.sv
cfgbus_doorbell.sv
cfgbus_target_stage.sv
cfgbus_top.sv
cfgbus_clkgen.sv
cfgbus_properties.sv
cfgbus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the configuration bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module cfgbus_tb -o cfgbus_sim

status=0
./obj_dir/cfgbus_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation passed"
